// ==== all.f ====
+incdir+source
source/gamePkg.sv
source/videoPkg.sv
source/pixelLocator.sv
source/titleBitmap.sv
source/subtitleText.sv
source/colorSelect.sv
source/uiGen.sv
sim/uiGen_checker.sv
sim/uiGenTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the uiGen testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f all.f --top-module uiGenTb -Mdir "$buildDir" -o uiGenTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/uiGenTb" +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test FAILED" "$logFile"; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0

// ==== sim/uiGenTb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ui_macros.svh"

module uiGenTb;
    import gamePkg::*;
    import videoPkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int LATENCY = 3;
    localparam int RANDOM_POINTS = 40;
    localparam int TITLE_W = `TITLE_COLS * `TITLE_SCALE;
    localparam int TITLE_H = `TITLE_ROWS * `TITLE_SCALE;
    localparam int SUB_W = `SUB_CHARS * `GLYPH_SIZE * `SUB_SCALE;
    localparam int SUB_H = `GLYPH_SIZE * `SUB_SCALE;

    typedef struct packed {
        gameState_t  state;
        pixelCoord_t col;
        pixelCoord_t row;
        color_t      expColor;
    } stim_t;

    logic        clk;
    logic        rstN;
    gameState_t  gameState;
    pixelCoord_t colPos;
    pixelCoord_t rowPos;
    color_t      color;

    logic [`TITLE_COLS-1:0] titleRef [0:`TITLE_ROWS-1];
    logic [7:0]             fontRef [0:`GLYPH_COUNT*`GLYPH_SIZE-1];
    string promptText = "PRESS ANY KEY TO CONTINUE";
    string glyphOrder = " ACEIKNOPRSTUY";  // Slot order of font.mem

    stim_t       stimTab [$];
    color_t      expQ [$];
    logic [31:0] rngState;
    int          cycleCount;
    int          cycleLimit;
    int          checkCount;
    int          valueErrors;
    int          resetErrors;

    uiGen uiGen_i (
        .clk(clk),
        .rstN(rstN),
        .gameState(gameState),
        .colPos(colPos),
        .rowPos(rowPos),
        .color(color)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int nextRandom(input int range);
        rngState = xorshift(rngState);
        return int'(rngState % 32'(range));
    endfunction

    function automatic int glyphIndex(input byte ch);
        for (int s = 0; s < glyphOrder.len(); s++) begin
            if (glyphOrder[s] == ch) return s;
        end
        return 0;
    endfunction

    function automatic color_t modelColor(input gameState_t state, input int col, input int row);
        int lc;
        int lr;
        int slot;
        if (state != MENU) return `COLOR_BLACK;
        if (col >= `TITLE_X && col < `TITLE_X + TITLE_W &&
            row >= `TITLE_Y && row < `TITLE_Y + TITLE_H) begin
            lc = (col - `TITLE_X) / `TITLE_SCALE;
            lr = (row - `TITLE_Y) / `TITLE_SCALE;
            return titleRef[lr][`TITLE_COLS - 1 - lc] ? `COLOR_RED : `COLOR_BLACK;
        end
        if (col >= `SUB_X && col < `SUB_X + SUB_W && row >= `SUB_Y && row < `SUB_Y + SUB_H) begin
            lc = (col - `SUB_X) / `SUB_SCALE;
            lr = (row - `SUB_Y) / `SUB_SCALE;
            slot = glyphIndex(promptText[lc / `GLYPH_SIZE]);
            return fontRef[slot * `GLYPH_SIZE + lr][lc % `GLYPH_SIZE] ? `COLOR_RED : `COLOR_BLACK;
        end
        return `COLOR_BLACK;
    endfunction

    task automatic addEntry(input gameState_t state, input int col, input int row);
        stim_t e;
        e.state = state;
        e.col = pixelCoord_t'(col);
        e.row = pixelCoord_t'(row);
        e.expColor = modelColor(state, col, row);
        stimTab.push_back(e);
    endtask

    task automatic buildTable();
        gameState_t st;
        // Title corners, then one past each edge
        addEntry(MENU, 124, 155);
        addEntry(MENU, 515, 155);
        addEntry(MENU, 124, 224);
        addEntry(MENU, 515, 224);
        addEntry(MENU, 123, 155);
        addEntry(MENU, 516, 155);
        addEntry(MENU, 124, 154);
        addEntry(MENU, 124, 225);
        addEntry(MENU, 131, 162);
        addEntry(MENU, 138, 224);   // Lit pixel in the last bitmap row
        // Subtitle corners, then one past each edge
        addEntry(MENU, 120, 320);
        addEntry(MENU, 519, 320);
        addEntry(MENU, 120, 335);
        addEntry(MENU, 519, 335);
        addEntry(MENU, 119, 320);
        addEntry(MENU, 520, 320);
        addEntry(MENU, 120, 319);
        addEntry(MENU, 120, 336);
        addEntry(MENU, 122, 320);
        addEntry(MENU, 514, 332);   // Last character, font row 6
        addEntry(MENU, 0, 0);
        addEntry(MENU, 639, 479);
        addEntry(PLAYING, 131, 162);
        addEntry(DEAD, 122, 320);
        addEntry(WIN, 131, 169);
        addEntry(PLAYING, 122, 322);
        for (int i = 0; i < RANDOM_POINTS; i++) begin
            case (nextRandom(8))
                0: st = PLAYING;
                1: st = DEAD;
                2: st = WIN;
                default: st = MENU;
            endcase
            if (i % 2 == 0) begin
                addEntry(st, `TITLE_X + nextRandom(TITLE_W), `TITLE_Y + nextRandom(TITLE_H));
            end else begin
                addEntry(st, `SUB_X + nextRandom(SUB_W), `SUB_Y + nextRandom(SUB_H));
            end
        end
    endtask

    // Watchdog on the whole run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the stream did not complete", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        stim_t  e;
        stim_t  idle;
        color_t expected;
        int     assertFails;
        clk = 1'b0;
        rstN = 1'b0;
        gameState = MENU;   // A red title pixel, held off by reset
        colPos = 10'd131;
        rowPos = 10'd162;
        rngState = 32'd54;
        cycleCount = 0;
        cycleLimit = 0;
        checkCount = 0;
        valueErrors = 0;
        resetErrors = 0;
        idle.state = DEAD;
        idle.col = '0;
        idle.row = '0;
        idle.expColor = `COLOR_BLACK;
        $readmemh("source/title.mem", titleRef);
        $readmemh("source/font.mem", fontRef);
        buildTable();
        cycleLimit = RESET_CYCLES + stimTab.size() + LATENCY + 20;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            checkCount++;
            if (color !== `COLOR_BLACK) begin
                $display("ERR %0t ns color: expected %h, got %h (in reset)",
                         $time, `COLOR_BLACK, color);
                resetErrors++;
            end
        end
        rstN = 1'b1;
        gameState = idle.state;
        colPos = idle.col;
        rowPos = idle.row;

        // One entry per cycle, each compared three edges later
        for (int i = 0; i < stimTab.size() + LATENCY; i++) begin
            @(posedge clk);
            #1;
            if (expQ.size() == LATENCY) begin
                expected = expQ.pop_front();
            end else begin
                expected = `COLOR_BLACK;
            end
            checkCount++;
            if (color !== expected) begin
                $display("ERR %0t ns color: expected %h, got %h (entry %0d)",
                         $time, expected, color, i - LATENCY);
                valueErrors++;
            end
            e = (i < stimTab.size()) ? stimTab[i] : idle;
            gameState = e.state;
            colPos = e.col;
            rowPos = e.row;
            expQ.push_back(e.expColor);
        end

        assertFails = uiGen_i.colorSelect_i.uiGen_checker_i.failCount;
        $display("Checks %0d, pixel errors %0d, reset errors %0d, assertion failures %0d",
                 checkCount, valueErrors, resetErrors, assertFails);
        if (valueErrors + resetErrors + assertFails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/uiGen_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ui_macros.svh"

module uiGen_checker (
    input logic              clk,
    input logic              rstN,
    input videoPkg::region_t regionDly,
    input videoPkg::color_t  color
);
    import videoPkg::*;

    int failCount = 0;

    colorLegal: assert property (@(posedge clk) disable iff (!rstN)
        color == `COLOR_RED || color == `COLOR_BLACK)
        else begin
            failCount++;
            $error("color %h is neither red nor black", color);
        end

    blackAfterReset: assert property (@(posedge clk) !rstN |=> color == `COLOR_BLACK)
        else begin
            failCount++;
            $error("color %h is not black after reset", color);
        end

    // A pixel outside every box must come out black
    noneIsBlack: assert property (@(posedge clk) disable iff (!rstN)
        regionDly == REGION_NONE |=> color == `COLOR_BLACK)
        else begin
            failCount++;
            $error("color %h is not black for an untagged pixel", color);
        end

endmodule

bind colorSelect uiGen_checker uiGen_checker_i (
    .clk(clk),
    .rstN(rstN),
    .regionDly(regionDly),
    .color(color)
);

`default_nettype wire

// ==== source/colorSelect.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ui_macros.svh"

module colorSelect (
    input  logic              clk,
    input  logic              rstN,
    input  videoPkg::region_t region,
    input  logic              titlePixel,
    input  logic              subPixel,
    output videoPkg::color_t  color
);
    import videoPkg::*;

    region_t regionDly;

    // Aligns the tag with the ROM outputs
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regionDly <= REGION_NONE;
        end else begin
            regionDly <= region;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            color <= `COLOR_BLACK;
        end else begin
            case (regionDly)
                REGION_TITLE:    color <= titlePixel ? `COLOR_RED : `COLOR_BLACK;
                REGION_SUBTITLE: color <= subPixel ? `COLOR_RED : `COLOR_BLACK;
                default:         color <= `COLOR_BLACK;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/font.mem ====
// 14 glyphs of 8 rows (space A C E I K N O P R S T U Y), bit 0 is the leftmost pixel
00
00
00
00
00
00
00
00
1C
22
22
3E
22
22
22
00
1C
22
02
02
02
22
1C
00
3E
02
02
1E
02
02
3E
00
1C
08
08
08
08
08
1C
00
22
12
0A
06
0A
12
22
00
22
26
2A
32
22
22
22
00
1C
22
22
22
22
22
1C
00
1E
22
22
1E
02
02
02
00
1E
22
22
1E
0A
12
22
00
3C
02
02
1C
20
20
1E
00
3E
08
08
08
08
08
08
00
22
22
22
22
22
22
1C
00
22
22
14
08
08
08
08
00

// ==== source/gamePkg.sv ====
`default_nettype none

package gamePkg;

    typedef enum logic [1:0] {MENU, PLAYING, DEAD, WIN} gameState_t;

endpackage

`default_nettype wire

// ==== source/pixelLocator.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ui_macros.svh"

module pixelLocator (
    input  logic                  clk,
    input  logic                  rstN,
    input  gamePkg::gameState_t   gameState,
    input  videoPkg::pixelCoord_t colPos,
    input  videoPkg::pixelCoord_t rowPos,
    output videoPkg::region_t     region,
    output videoPkg::pixelCoord_t titleCol,
    output videoPkg::pixelCoord_t titleRow,
    output videoPkg::pixelCoord_t subCol,
    output videoPkg::pixelCoord_t subRow
);
    import gamePkg::*;
    import videoPkg::*;

    localparam pixelCoord_t TITLE_X0 = pixelCoord_t'(`TITLE_X);
    localparam pixelCoord_t TITLE_Y0 = pixelCoord_t'(`TITLE_Y);
    localparam pixelCoord_t TITLE_W = pixelCoord_t'(`TITLE_COLS * `TITLE_SCALE);
    localparam pixelCoord_t TITLE_H = pixelCoord_t'(`TITLE_ROWS * `TITLE_SCALE);
    localparam pixelCoord_t TITLE_S = pixelCoord_t'(`TITLE_SCALE);
    localparam pixelCoord_t SUB_X0 = pixelCoord_t'(`SUB_X);
    localparam pixelCoord_t SUB_Y0 = pixelCoord_t'(`SUB_Y);
    localparam pixelCoord_t SUB_W = pixelCoord_t'(`SUB_CHARS * `GLYPH_SIZE * `SUB_SCALE);
    localparam pixelCoord_t SUB_H = pixelCoord_t'(`GLYPH_SIZE * `SUB_SCALE);
    localparam pixelCoord_t SUB_S = pixelCoord_t'(`SUB_SCALE);

    pixelCoord_t titleDx;
    pixelCoord_t titleDy;
    pixelCoord_t subDx;
    pixelCoord_t subDy;
    logic        inTitle;
    logic        inSub;

    assign titleDx = colPos - TITLE_X0;
    assign titleDy = rowPos - TITLE_Y0;
    assign subDx = colPos - SUB_X0;
    assign subDy = rowPos - SUB_Y0;

    // Lower bound first so the wrapped difference is never trusted
    assign inTitle = colPos >= TITLE_X0 && titleDx < TITLE_W &&
                     rowPos >= TITLE_Y0 && titleDy < TITLE_H;
    assign inSub = colPos >= SUB_X0 && subDx < SUB_W &&
                   rowPos >= SUB_Y0 && subDy < SUB_H;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            region <= REGION_NONE;
        end else if (gameState == MENU && inTitle) begin
            region <= REGION_TITLE;
        end else if (gameState == MENU && inSub) begin
            region <= REGION_SUBTITLE;
        end else begin
            region <= REGION_NONE;
        end
    end

    // Zero outside the box keeps ROM addresses in range
    always_ff @(posedge clk) begin
        if (!rstN) begin
            titleCol <= '0;
            titleRow <= '0;
            subCol <= '0;
            subRow <= '0;
        end else begin
            titleCol <= inTitle ? titleDx / TITLE_S : '0;
            titleRow <= inTitle ? titleDy / TITLE_S : '0;
            subCol <= inSub ? subDx / SUB_S : '0;
            subRow <= inSub ? subDy / SUB_S : '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/subtitleText.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ui_macros.svh"

module subtitleText (
    input  logic                  clk,
    input  logic                  rstN,
    input  videoPkg::pixelCoord_t subCol,
    input  videoPkg::pixelCoord_t subRow,
    output logic                  subPixel
);

    localparam logic [8*`SUB_CHARS-1:0] PROMPT = "PRESS ANY KEY TO CONTINUE";

    logic [7:0] fontRom [0:`GLYPH_COUNT*`GLYPH_SIZE-1];
    logic [4:0] charIndex;
    logic [7:0] ascii;
    logic [6:0] fontAddr;

    initial begin
        $readmemh("source/font.mem", fontRom);
    end

    // Slot order follows font.mem
    function automatic logic [3:0] glyphSlot(input logic [7:0] ch);
        case (ch)
            "A": glyphSlot = 4'd1;
            "C": glyphSlot = 4'd2;
            "E": glyphSlot = 4'd3;
            "I": glyphSlot = 4'd4;
            "K": glyphSlot = 4'd5;
            "N": glyphSlot = 4'd6;
            "O": glyphSlot = 4'd7;
            "P": glyphSlot = 4'd8;
            "R": glyphSlot = 4'd9;
            "S": glyphSlot = 4'd10;
            "T": glyphSlot = 4'd11;
            "U": glyphSlot = 4'd12;
            "Y": glyphSlot = 4'd13;
            default: glyphSlot = 4'd0;  // Space
        endcase
    endfunction

    assign charIndex = subCol[7:3];
    assign ascii = PROMPT[(`SUB_CHARS - 1 - int'(charIndex)) * 8 +: 8];  // First char in MSBs
    assign fontAddr = {glyphSlot(ascii), subRow[2:0]};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            subPixel <= 1'b0;
        end else begin
            subPixel <= fontRom[fontAddr][subCol[2:0]];  // Bit 0 is leftmost
        end
    end

endmodule

`default_nettype wire

// ==== source/title.mem ====
// One title row per line, 56 bits, bit 55 is the leftmost column
00000000000000
447C7C7C38783C
6C401040444440
54401040444440
54781078447838
44401040445004
44401040444804
447C107C384478
00000000000000
3FFFFFFFFFFFFC

// ==== source/titleBitmap.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ui_macros.svh"

module titleBitmap (
    input  logic                  clk,
    input  logic                  rstN,
    input  videoPkg::pixelCoord_t titleCol,
    input  videoPkg::pixelCoord_t titleRow,
    output logic                  titlePixel
);

    logic [`TITLE_COLS-1:0] titleRom [0:`TITLE_ROWS-1];
    logic [5:0]             bitIdx;
    logic [3:0]             rowIdx;

    initial begin
        $readmemh("source/title.mem", titleRom);
    end

    // Bit 55 is the leftmost column
    assign bitIdx = 6'(`TITLE_COLS - 1) - titleCol[5:0];
    assign rowIdx = titleRow[3:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            titlePixel <= 1'b0;
        end else begin
            titlePixel <= titleRom[rowIdx][bitIdx];
        end
    end

endmodule

`default_nettype wire

// ==== source/uiGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module uiGen (
    input  logic                  clk,
    input  logic                  rstN,
    input  gamePkg::gameState_t   gameState,
    input  videoPkg::pixelCoord_t colPos,
    input  videoPkg::pixelCoord_t rowPos,
    output videoPkg::color_t      color
);
    import videoPkg::*;

    region_t     region;
    pixelCoord_t titleCol;
    pixelCoord_t titleRow;
    pixelCoord_t subCol;
    pixelCoord_t subRow;
    logic        titlePixel;
    logic        subPixel;

    pixelLocator pixelLocator_i (
        .clk(clk),
        .rstN(rstN),
        .gameState(gameState),
        .colPos(colPos),
        .rowPos(rowPos),
        .region(region),
        .titleCol(titleCol),
        .titleRow(titleRow),
        .subCol(subCol),
        .subRow(subRow)
    );

    titleBitmap titleBitmap_i (
        .clk(clk),
        .rstN(rstN),
        .titleCol(titleCol),
        .titleRow(titleRow),
        .titlePixel(titlePixel)
    );

    subtitleText subtitleText_i (
        .clk(clk),
        .rstN(rstN),
        .subCol(subCol),
        .subRow(subRow),
        .subPixel(subPixel)
    );

    colorSelect colorSelect_i (
        .clk(clk),
        .rstN(rstN),
        .region(region),    // Delayed inside to meet the ROM outputs
        .titlePixel(titlePixel),
        .subPixel(subPixel),
        .color(color)
    );

endmodule

`default_nettype wire

// ==== source/ui_macros.svh ====
`ifndef UI_MACROS_SVH
`define UI_MACROS_SVH

// Title box, centered on column 320
`define TITLE_X 124
`define TITLE_Y 155
`define TITLE_SCALE 7
`define TITLE_COLS 56
`define TITLE_ROWS 10

// Prompt box under the title
`define SUB_X 120
`define SUB_Y 320
`define SUB_SCALE 2
`define SUB_CHARS 25

// Font cell and glyph table size
`define GLYPH_SIZE 8
`define GLYPH_COUNT 14

// RGB222 colors
`define COLOR_RED 6'b110000
`define COLOR_BLACK 6'b000000

`endif

// ==== source/videoPkg.sv ====
`default_nettype none

package videoPkg;

    typedef logic [9:0] pixelCoord_t;   // Screen or box-local position
    typedef logic [5:0] color_t;        // RGB222

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_TITLE,
        REGION_SUBTITLE
    } region_t;

endpackage

`default_nettype wire
